/* build.f */
+incdir+hdl
hdl/extmem_pkg.sv
hdl/extmem_ifs.sv
hdl/bus_front.sv
hdl/fetch_cache.sv
hdl/sram_sequencer.sv
hdl/extmem_top.sv
verification/sram_model.sv
verification/extmem_tb.sv

/* Makefile */
# Verilator simulation of the external memory subsystem

VERILATOR ?= verilator
TOP       ?= extmem_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/extmem_tb.sv */
// Table-driven testbench for the external memory subsystem with cache and RAM cycle checks

`timescale 1ns/100ps
`default_nettype none

`include "extmem_defines.svh"

module extmem_tb;
   import extmem_pkg::*;

   localparam logic [1:0] op_write = 2'd0;
   localparam logic [1:0] op_read  = 2'd1;
   localparam logic [1:0] op_fetch = 2'd2;
   localparam int num_entries    = 22;
   localparam int timeout_cycles = num_entries * 12 + 50;

   typedef struct packed {
      logic [1:0]                op;
      logic                      rand_data;
      logic [`EXTMEM_AWIDTH-1:0] addr;
      logic [`EXTMEM_DWIDTH-1:0] data;
      logic [1:0]                ram_count;
   } entry_t;

   // ------------------------------------------------------------------------
   // Stimulus table of operation, random data flag, address, write data and RAM accesses
   // ------------------------------------------------------------------------
   localparam entry_t stimulus [num_entries] = '{
      '{op_write, 1'b0, 20'h00010, 32'h1234_5678, 2'd1},
      '{op_read,  1'b0, 20'h00010, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00123, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00123, 32'h0,         2'd0},
      // Same index, other tag
      '{op_fetch, 1'b0, 20'h00453, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00123, 32'h0,         2'd1},
      '{op_write, 1'b1, 20'h00123, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00123, 32'h0,         2'd0},
      // Data read leaves the cache alone
      '{op_read,  1'b0, 20'h00234, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00234, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00234, 32'h0,         2'd0},
      '{op_write, 1'b1, 20'h00453, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00123, 32'h0,         2'd0},
      '{op_fetch, 1'b0, 20'h00453, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00010, 32'h0,         2'd1},
      '{op_read,  1'b0, 20'h00010, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00010, 32'h0,         2'd0},
      '{op_write, 1'b0, 20'h1f0a0, 32'hcafe_f00d, 2'd1},
      '{op_fetch, 1'b0, 20'h00010, 32'h0,         2'd0},
      '{op_fetch, 1'b0, 20'h1f0a0, 32'h0,         2'd1},
      '{op_fetch, 1'b0, 20'h00010, 32'h0,         2'd1},
      '{op_read,  1'b0, 20'h1f0a0, 32'h0,         2'd1}
   };

   logic                      clock;
   logic                      reset_b;
   logic                      cyc;
   logic                      stb;
   logic                      we;
   logic                      fetch;
   logic [`EXTMEM_AWIDTH-1:0] adr;
   logic [`EXTMEM_DWIDTH-1:0] dat_w;
   logic [`EXTMEM_DWIDTH-1:0] dat_r;
   logic                      ack;
   logic                      ram_cs_b;
   logic                      ram_oe_b;
   logic                      ram_we_b;
   logic [ram_addr_width-1:0] ram_addr;
   logic [half_width-1:0]     ram_data_out;
   logic                      ram_data_oe;
   wire  [half_width-1:0]     ram_dq;

   int seed = 58380;
   int errors = 0;
   int checks = 0;
   int cycle_count = 0;
   int cs_falls = 0;

   // Reference memory and shadow of the direct-mapped cache
   logic [`EXTMEM_DWIDTH-1:0] ref_mem [logic [ram_word_width-1:0]];
   logic                      sc_valid [1 << `EXTMEM_INDEX_BITS];
   logic [tag_width-1:0]      sc_tag [1 << `EXTMEM_INDEX_BITS];

   extmem_top dut_i (
      .clock        (clock),
      .reset_b      (reset_b),
      .cyc          (cyc),
      .stb          (stb),
      .we           (we),
      .fetch        (fetch),
      .adr          (adr),
      .dat_w        (dat_w),
      .dat_r        (dat_r),
      .ack          (ack),
      .ram_cs_b     (ram_cs_b),
      .ram_oe_b     (ram_oe_b),
      .ram_we_b     (ram_we_b),
      .ram_addr     (ram_addr),
      .ram_data_out (ram_data_out),
      .ram_data_in  (ram_dq),
      .ram_data_oe  (ram_data_oe)
   );

   // DUT drives the shared bus on writes, the SRAM on reads
   assign ram_dq = ram_data_oe ? ram_data_out : 'z;

   sram_model sram_i (
      .ram_cs_b (ram_cs_b),
      .ram_oe_b (ram_oe_b),
      .ram_we_b (ram_we_b),
      .ram_addr (ram_addr),
      .ram_data (ram_dq)
   );

   always #20 clock = ~clock;

   // One falling chip select per word access
   always @(negedge ram_cs_b)
      cs_falls <= cs_falls + 1;

   always @(posedge clock) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout after %0d cycles, the DUT stopped acknowledging", cycle_count);
         $display("Test failed");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // Same preset as the SRAM model holds before any write
   function automatic logic [half_width-1:0] preset_half(input logic [17:0] a);
      return a[15:0] ^ {a[17:16], a[17:16], 12'h5a3};
   endfunction

   function automatic logic [31:0] expected_word(input logic [ram_word_width-1:0] w);
      if (ref_mem.exists(w))
         return ref_mem[w];
      return {preset_half({w, 1'b1}), preset_half({w, 1'b0})};
   endfunction

   function automatic string op_name(input logic [1:0] op);
      case (op)
         op_write: return "write";
         op_read:  return "read";
         default:  return "fetch";
      endcase
   endfunction

   // Classic cycle holds the request until ack and releases it one edge later
   task automatic bus_access(input logic [1:0] op, input logic [`EXTMEM_AWIDTH-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
      @(posedge clock);
      #2;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = (op == op_write);
      fetch = (op == op_fetch);
      adr   = addr;
      dat_w = wdata;
      do begin
         @(posedge clock);
         #2;
      end while (!ack);
      rdata = dat_r;
      @(posedge clock);
      #2;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      fetch = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      entry_t                        e;
      string                         name;
      logic [31:0]                   wdata;
      logic [31:0]                   rdata;
      logic [ram_word_width-1:0]     w;
      logic [`EXTMEM_INDEX_BITS-1:0] idx;
      logic [tag_width-1:0]          tag;
      logic                          hit;
      int                            predicted;
      int                            falls_before;

      clock   = 1'b0;
      reset_b = 1'b0;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      fetch   = 1'b0;
      adr     = '0;
      dat_w   = '0;
      for (int i = 0; i < (1 << `EXTMEM_INDEX_BITS); i++)
         sc_valid[i] = 1'b0;

      // Bus and SRAM pins quiet in reset and while idle after it
      for (int c = 0; c < 8; c++) begin
         @(posedge clock);
         #2;
         if (c == 3)
            reset_b = 1'b1;
         check_value("idle ack", 32'd0, 32'(ack));
         check_value("idle ram_cs_b", 32'd1, 32'(ram_cs_b));
         check_value("idle ram_oe_b", 32'd1, 32'(ram_oe_b));
         check_value("idle ram_we_b", 32'd1, 32'(ram_we_b));
         check_value("idle ram_data_oe", 32'd0, 32'(ram_data_oe));
      end
      check_value("idle ram accesses", 32'd0, 32'(cs_falls));

      for (int i = 0; i < num_entries; i++) begin
         e     = stimulus[i];
         wdata = e.rand_data ? $random(seed) : e.data;
         w     = e.addr[ram_word_width-1:0];
         idx   = e.addr[`EXTMEM_INDEX_BITS-1:0];
         tag   = e.addr[`EXTMEM_AWIDTH-1:`EXTMEM_INDEX_BITS];
         hit   = sc_valid[idx] && (sc_tag[idx] == tag);
         // Only a fetch hit skips the RAM
         predicted = (e.op == op_fetch && hit) ? 0 : 1;
         name      = $sformatf("entry %0d %s %05h", i, op_name(e.op), e.addr);
         check_value({name, " table count"}, 32'(predicted), 32'(e.ram_count));

         falls_before = cs_falls;
         bus_access(e.op, e.addr, wdata, rdata);
         check_value({name, " ram accesses"}, 32'(e.ram_count), 32'(cs_falls - falls_before));

         if (e.op == op_write)
            ref_mem[w] = wdata;
         else
            check_value({name, " data"}, expected_word(w), rdata);

         // Fetch miss replaces the entry
         if (e.op == op_fetch && !hit) begin
            sc_valid[idx] = 1'b1;
            sc_tag[idx]   = tag;
         end
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verification/sram_model.sv */
// Behavioral 16-bit asynchronous SRAM with a tristate data bus and an address-derived preset

`timescale 1ns/100ps
`default_nettype none

module sram_model (
   input wire logic                                 ram_cs_b,
   input wire logic                                 ram_oe_b,
   input wire logic                                 ram_we_b,
   input wire logic [extmem_pkg::ram_addr_width-1:0] ram_addr,
   inout wire logic [extmem_pkg::half_width-1:0]     ram_data
);
   import extmem_pkg::*;

   localparam int depth = 1 << ram_addr_width;

   logic [half_width-1:0] mem [depth];

   // Preset mixes every address bit, so a wrong address shows up as wrong data
   function automatic logic [half_width-1:0] preset_half(input logic [17:0] a);
      return a[15:0] ^ {a[17:16], a[17:16], 12'h5a3};
   endfunction

   initial begin
      for (int a = 0; a < depth; a++)
         mem[a] = preset_half(18'(a));
   end

   // Write lands on the rising edge of the strobe
   always @(posedge ram_we_b) begin
      if (!ram_cs_b)
         mem[ram_addr] <= ram_data;
   end

   // Drive the bus only for a read with the strobe high
   assign ram_data = (!ram_cs_b && !ram_oe_b && ram_we_b) ? mem[ram_addr] : 'z;

endmodule

`default_nettype wire

/* hdl/extmem_top.sv */
// External memory subsystem top level with Wishbone slave pins and 16-bit SRAM pins

`timescale 1ns/100ps
`default_nettype none

`include "extmem_defines.svh"

module extmem_top (
   input  wire logic                                 clock,
   input  wire logic                                 reset_b,
   // Wishbone classic slave
   input  wire logic                                 cyc,
   input  wire logic                                 stb,
   input  wire logic                                 we,
   input  wire logic                                 fetch,
   input  wire logic [`EXTMEM_AWIDTH-1:0]             adr,
   input  wire logic [`EXTMEM_DWIDTH-1:0]             dat_w,
   output logic      [`EXTMEM_DWIDTH-1:0]             dat_r,
   output logic                                      ack,
   // Asynchronous SRAM
   output logic                                      ram_cs_b,
   output logic                                      ram_oe_b,
   output logic                                      ram_we_b,
   output logic      [extmem_pkg::ram_addr_width-1:0] ram_addr,
   output logic      [extmem_pkg::half_width-1:0]     ram_data_out,
   input  wire logic [extmem_pkg::half_width-1:0]     ram_data_in,
   output logic                                      ram_data_oe
);

   cache_if    cache_link ();
   sram_req_if sram_link ();

   // Bus front end, decides between cache hit and RAM access
   bus_front bus_front_i (
      .clock   (clock),
      .reset_b (reset_b),
      .cyc     (cyc),
      .stb     (stb),
      .we      (we),
      .fetch   (fetch),
      .adr     (adr),
      .dat_w   (dat_w),
      .dat_r   (dat_r),
      .ack     (ack),
      .cache   (cache_link.requester),
      .sram    (sram_link.requester)
   );

   fetch_cache fetch_cache_i (
      .clock   (clock),
      .reset_b (reset_b),
      .port    (cache_link.cache)
   );

   // Two half-word accesses per word
   sram_sequencer sram_sequencer_i (
      .clock        (clock),
      .reset_b      (reset_b),
      .req          (sram_link.sequencer),
      .ram_cs_b     (ram_cs_b),
      .ram_oe_b     (ram_oe_b),
      .ram_we_b     (ram_we_b),
      .ram_addr     (ram_addr),
      .ram_data_out (ram_data_out),
      .ram_data_in  (ram_data_in),
      .ram_data_oe  (ram_data_oe)
   );

endmodule

`default_nettype wire

/* hdl/sram_sequencer.sv */
// Sequencer that splits a 32-bit word into two timed 16-bit asynchronous SRAM accesses

`timescale 1ns/100ps
`default_nettype none

`include "extmem_defines.svh"

module sram_sequencer (
   input  wire logic                                 clock,
   input  wire logic                                 reset_b,
   sram_req_if.sequencer                             req,
   output logic                                      ram_cs_b,
   output logic                                      ram_oe_b,
   output logic                                      ram_we_b,
   output logic      [extmem_pkg::ram_addr_width-1:0] ram_addr,
   output logic      [extmem_pkg::half_width-1:0]     ram_data_out,
   input  wire logic [extmem_pkg::half_width-1:0]     ram_data_in,
   output logic                                      ram_data_oe
);
   import extmem_pkg::*;

   localparam logic [count_width-1:0] last_count = count_width'(2 * `EXTMEM_HALF_CYCLES - 1);

   logic                   busy;
   logic [count_width-1:0] count;
   logic                   half_sel;
   logic [count_width-2:0] phase;
   logic                   we_b_q;
   logic [half_width-1:0]  low_half;

   // ------------------------------------------------------------------------
   // Cycle counter
   // ------------------------------------------------------------------------
   always_ff @(posedge clock) begin
      if (!reset_b) begin
         busy  <= 1'b0;
         count <= '0;
      end else if (busy) begin
         count <= count + 1'b1;
         if (count == last_count)
            busy <= 1'b0;
      end else if (req.start) begin
         busy  <= 1'b1;
         count <= '0;
      end
   end

   // Top bit picks the half-word, the rest is the cycle within it
   assign half_sel = count[count_width-1];
   assign phase    = count[count_width-2:0];

   // ------------------------------------------------------------------------
   // Write strobe
   // ------------------------------------------------------------------------

   // Low in cycles 1-2 and 5-6, one cycle of setup before and hold after
   // Registered so the strobe never glitches
   always_ff @(posedge clock) begin
      if (!reset_b)
         we_b_q <= 1'b1;
      else
         we_b_q <= !(busy && req.write && !phase[count_width-2]);
   end

   // ------------------------------------------------------------------------
   // Read data
   // ------------------------------------------------------------------------

   // Low half captured at end of cycle 3
   always_ff @(posedge clock) begin
      if (busy && !half_sel && (&phase))
         low_half <= ram_data_in;
   end

   // High half taken straight off the bus in the last cycle
   assign req.rdata = {ram_data_in, low_half};
   assign req.done  = busy && (count == last_count);

   // ------------------------------------------------------------------------
   // SRAM pins
   // ------------------------------------------------------------------------
   assign ram_cs_b     = !busy;
   assign ram_oe_b     = !(busy && !req.write);
   assign ram_we_b     = we_b_q;
   assign ram_addr     = {req.addr.ram.word, half_sel};
   assign ram_data_oe  = busy && req.write;
   assign ram_data_out = half_sel ? req.wdata[`EXTMEM_DWIDTH-1:half_width]
                                  : req.wdata[half_width-1:0];

   // Never drive and read the data bus at once
   a_oe_we_exclusive: assert property (@(posedge clock) disable iff (!reset_b)
      !(!ram_oe_b && !ram_we_b));

   // Front end must wait for done before starting again
   a_start_when_idle: assert property (@(posedge clock) disable iff (!reset_b)
      req.start |-> !busy);

endmodule

`default_nettype wire

/* hdl/fetch_cache.sv */
// Direct-mapped instruction cache holding a valid bit, a tag and one word per entry

`timescale 1ns/100ps
`default_nettype none

`include "extmem_defines.svh"

module fetch_cache (
   input wire logic clock,
   input wire logic reset_b,
   cache_if.cache   port
);
   import extmem_pkg::*;

   localparam int entries = 1 << `EXTMEM_INDEX_BITS;

   logic [entries-1:0]            valid;
   logic [tag_width-1:0]          tag_mem  [entries];
   logic [`EXTMEM_DWIDTH-1:0]     data_mem [entries];
   logic [`EXTMEM_INDEX_BITS-1:0] index;
   logic [tag_width-1:0]          tag;
   logic                          tag_match;

   // ------------------------------------------------------------------------
   // Lookup
   // ------------------------------------------------------------------------
   assign index     = port.lookup_addr.cache.index;
   assign tag       = port.lookup_addr.cache.tag;
   assign tag_match = valid[index] && (tag_mem[index] == tag);

   assign port.hit      = tag_match;
   assign port.hit_data = data_mem[index];

   // ------------------------------------------------------------------------
   // Fill and update
   // ------------------------------------------------------------------------

   // Every entry starts invalid and becomes valid with its first fill
   always_ff @(posedge clock) begin
      if (!reset_b)
         valid <= '0;
      else if (port.fill_en)
         valid[index] <= 1'b1;
   end

   // Fill replaces the entry, a write only touches it when it is the cached word
   always_ff @(posedge clock) begin
      if (port.fill_en) begin
         tag_mem[index]  <= tag;
         data_mem[index] <= port.fill_data;
      end else if (port.update_en && tag_match) begin
         data_mem[index] <= port.update_data;
      end
   end

   // A completed access is either a fetch fill or a write update
   a_fill_xor_update: assert property (@(posedge clock) disable iff (!reset_b)
      !(port.fill_en && port.update_en));

endmodule

`default_nettype wire

/* hdl/bus_front.sv */
// Wishbone classic slave that serves fetch hits from the cache and sends the rest to SRAM

`timescale 1ns/100ps
`default_nettype none

`include "extmem_defines.svh"

module bus_front (
   input  wire logic                      clock,
   input  wire logic                      reset_b,
   input  wire logic                      cyc,
   input  wire logic                      stb,
   input  wire logic                      we,
   input  wire logic                      fetch,
   input  wire extmem_pkg::word_addr_u    adr,
   input  wire logic [`EXTMEM_DWIDTH-1:0] dat_w,
   output logic      [`EXTMEM_DWIDTH-1:0] dat_r,
   output logic                           ack,
   cache_if.requester                     cache,
   sram_req_if.requester                  sram
);
   import extmem_pkg::*;

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_ram  = 2'd1;
   localparam logic [1:0] st_ack  = 2'd2;

   logic [1:0]                state;
   logic                      bus_free;
   logic                      start_q;
   logic                      ram_done;
   // Request captured at accept, held for the whole RAM access
   word_addr_u                req_addr;
   logic                      req_we;
   logic                      req_fetch;
   logic [`EXTMEM_DWIDTH-1:0] req_data;

   // ------------------------------------------------------------------------
   // Controller
   // ------------------------------------------------------------------------
   always_ff @(posedge clock) begin
      if (!reset_b) begin
         state    <= st_idle;
         ack      <= 1'b0;
         start_q  <= 1'b0;
         bus_free <= 1'b1;
      end else begin
         ack     <= 1'b0;
         start_q <= 1'b0;
         // Master has let go of the bus, next strobe is a new request
         if (!(cyc && stb))
            bus_free <= 1'b1;
         case (state)
            st_idle: begin
               if (cyc && stb && bus_free) begin
                  bus_free <= 1'b0;
                  if (fetch && !we && cache.hit) begin
                     ack   <= 1'b1;
                     state <= st_ack;
                  end else begin
                     start_q <= 1'b1;
                     state   <= st_ram;
                  end
               end
            end
            st_ram: begin
               if (ram_done) begin
                  ack   <= 1'b1;
                  state <= st_ack;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Request payload and read data register
   always_ff @(posedge clock) begin
      if (state == st_idle && cyc && stb && bus_free) begin
         req_addr  <= adr;
         req_we    <= we;
         req_fetch <= fetch;
         req_data  <= dat_w;
         dat_r     <= cache.hit_data;
      end else if (ram_done) begin
         dat_r <= sram.rdata;
      end
   end

   assign ram_done = (state == st_ram) && sram.done;

   // Live bus address for the hit check, latched one during the RAM access
   assign cache.lookup_addr = (state == st_idle) ? adr : req_addr;
   // Fills only after instruction fetches, updates after every write
   assign cache.fill_en     = ram_done && req_fetch && !req_we;
   assign cache.fill_data   = sram.rdata;
   assign cache.update_en   = ram_done && req_we;
   assign cache.update_data = req_data;

   assign sram.start = start_q;
   assign sram.write = req_we;
   assign sram.addr  = req_addr;
   assign sram.wdata = req_data;

   // Acknowledge never outlives the master's request
   a_ack_in_cycle: assert property (@(posedge clock) disable iff (!reset_b)
      ack |-> (cyc && stb));

endmodule

`default_nettype wire

/* hdl/extmem_ifs.sv */
// Internal links between the bus front end, the fetch cache and the SRAM sequencer

`timescale 1ns/100ps
`default_nettype none

`include "extmem_defines.svh"

// ---------------------------------------------------------------------------
// Cache lookup, fill and update
// ---------------------------------------------------------------------------
interface cache_if;
   import extmem_pkg::*;

   word_addr_u                lookup_addr;
   logic                      fill_en;
   logic [`EXTMEM_DWIDTH-1:0] fill_data;
   logic                      update_en;
   logic [`EXTMEM_DWIDTH-1:0] update_data;
   // Both combinational from the cache array
   logic                      hit;
   logic [`EXTMEM_DWIDTH-1:0] hit_data;

   modport requester (output lookup_addr, fill_en, fill_data, update_en, update_data,
                      input hit, hit_data);
   modport cache (input lookup_addr, fill_en, fill_data, update_en, update_data,
                  output hit, hit_data);
endinterface

// ---------------------------------------------------------------------------
// One word access request to the SRAM sequencer
// ---------------------------------------------------------------------------
interface sram_req_if;
   import extmem_pkg::*;

   // start is a single-cycle pulse, only while the sequencer is idle
   logic                      start;
   logic                      write;
   word_addr_u                addr;
   logic [`EXTMEM_DWIDTH-1:0] wdata;
   // rdata only meaningful while done is high
   logic                      done;
   logic [`EXTMEM_DWIDTH-1:0] rdata;

   modport requester (output start, write, addr, wdata, input done, rdata);
   modport sequencer (input start, write, addr, wdata, output done, rdata);
endinterface

`default_nettype wire

/* hdl/extmem_pkg.sv */
// Shared types and derived widths for the external memory subsystem

`default_nettype none

`include "extmem_defines.svh"

package extmem_pkg;

   // Tag is whatever is left above the cache index
   localparam int tag_width = `EXTMEM_AWIDTH - `EXTMEM_INDEX_BITS;

   // SRAM holds 2 ** 17 words of 32 bits as 2 ** 18 half-words
   localparam int ram_word_width = 17;
   localparam int ram_addr_width = ram_word_width + 1;

   // Half of a CPU word goes over the SRAM data bus at a time
   localparam int half_width = `EXTMEM_DWIDTH / 2;

   // Counter spans both half-word windows
   localparam int count_width = $clog2(2 * `EXTMEM_HALF_CYCLES);

   // One word address, seen by the cache and by the RAM differently
   typedef union packed {
      struct packed {
         logic [tag_width-1:0]          tag;
         logic [`EXTMEM_INDEX_BITS-1:0] index;
      } cache;
      struct packed {
         logic [`EXTMEM_AWIDTH-ram_word_width-1:0] unused;
         logic [ram_word_width-1:0]                word;
      } ram;
   } word_addr_u;

endpackage

`default_nettype wire

/* hdl/extmem_defines.svh */
// External memory subsystem widths and access timing constants

`ifndef EXTMEM_DEFINES_SVH
`define EXTMEM_DEFINES_SVH

// ---------------------------------------------------------------------------
// CPU side
// ---------------------------------------------------------------------------

// Width of one CPU data word
`define EXTMEM_DWIDTH 32

// Width of the CPU word address
`define EXTMEM_AWIDTH 20

// ---------------------------------------------------------------------------
// Cache and RAM timing
// ---------------------------------------------------------------------------

// Direct-mapped cache has 2 ** EXTMEM_INDEX_BITS entries
`define EXTMEM_INDEX_BITS 4

// Clock cycles spent on each 16-bit half-word of the SRAM
`define EXTMEM_HALF_CYCLES 4

`endif
